/* compile.f */
design/core_pkg.sv
design/core_control.sv
design/cycle_counter.sv
design/inst_decode.sv
design/alu_unit.sv
design/reg_file.sv
design/data_ram.sv
design/sim_top.sv
sim/sim_top_properties.sv
sim/tb_sim_top.sv

/* design/alu_unit.sv */
// alu for arithmetic, logic, addresses and branch decisions
`timescale 1ns/1ns

module alu_unit (
  input  core_pkg::decode_t dec_i,
  input  core_pkg::xlen_t   rs1_data_i,
  input  core_pkg::xlen_t   rs2_data_i,
  input  core_pkg::addr_t   pc_i,
  output core_pkg::xlen_t   result_o,
  output logic              branch_taken_o
);

  core_pkg::xlen_t op_b;

  // register forms carry imm zero, immediate forms read x0 as rs2
  assign op_b = rs2_data_i | dec_i.imm;

  always_comb begin
    case (dec_i.op_class)
      core_pkg::CLS_ALU: begin
        case (dec_i.funct3)
          3'b100:  result_o = rs1_data_i ^ op_b;
          3'b110:  result_o = rs1_data_i | op_b;
          3'b111:  result_o = rs1_data_i & op_b;
          default: result_o = dec_i.sub ? rs1_data_i - op_b : rs1_data_i + op_b;
        endcase
      end
      core_pkg::CLS_LOAD,
      core_pkg::CLS_STORE:  result_o = rs1_data_i + dec_i.imm;
      // branch target
      core_pkg::CLS_BRANCH: result_o = pc_i + dec_i.imm;
      default:              result_o = '0;
    endcase
  end

  // funct3 bit 0 selects bne
  assign branch_taken_o = (dec_i.op_class == core_pkg::CLS_BRANCH)
                          && ((rs1_data_i == rs2_data_i) ^ dec_i.funct3[0]);

endmodule

/* design/core_control.sv */
// instruction sequencer FSM holding the pc and instruction register
`timescale 1ns/1ns

module core_control (
  input  logic                clock_i,
  input  logic                reset_i,
  input  core_pkg::inst_t     imem_data_i,
  input  core_pkg::decode_t   dec_i,
  input  core_pkg::xlen_t     alu_result_i,
  input  logic                branch_taken_i,
  input  core_pkg::xlen_t     rs1_data_i,
  input  core_pkg::xlen_t     mem_rdata_i,
  output core_pkg::addr_t     imem_addr_o,
  output logic                reg_we_o,
  output core_pkg::xlen_t     reg_wdata_o,
  output logic                mem_we_o,
  output core_pkg::inst_t     inst_o,
  output core_pkg::commit_t   commit_o,
  output logic                putch_valid_o,
  output logic [7:0]          putch_ch_o,
  output logic                halt_o,
  output logic [7:0]          trap_code_o
);

  core_pkg::ctrl_state_e state_q;
  core_pkg::ctrl_state_e state_d;
  core_pkg::addr_t       pc_q;
  core_pkg::inst_t       inst_q;
  core_pkg::xlen_t       result_q;
  core_pkg::xlen_t       load_q;
  logic                  taken_q;
  logic [7:0]            a0_lo_q;
  logic [7:0]            trap_code_q;
  logic                  in_wb;
  logic                  is_trap;
  logic                  is_load;

  assign in_wb   = (state_q == core_pkg::ST_WRITEBACK);
  assign is_trap = (dec_i.op_class == core_pkg::CLS_TRAP);
  assign is_load = (dec_i.op_class == core_pkg::CLS_LOAD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::ST_FETCH:  state_d = core_pkg::ST_DECODE;
      core_pkg::ST_DECODE: state_d = core_pkg::ST_EXECUTE;
      core_pkg::ST_EXECUTE: begin
        if (is_load || dec_i.op_class == core_pkg::CLS_STORE) begin
          state_d = core_pkg::ST_MEMORY;
        end else if (dec_i.op_class == core_pkg::CLS_ILLEGAL) begin
          state_d = core_pkg::ST_HALT;
        end else begin
          state_d = core_pkg::ST_WRITEBACK;
        end
      end
      core_pkg::ST_MEMORY:    state_d = core_pkg::ST_WRITEBACK;
      core_pkg::ST_WRITEBACK: state_d = is_trap ? core_pkg::ST_HALT : core_pkg::ST_FETCH;
      default:                state_d = core_pkg::ST_HALT;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q     <= core_pkg::ST_FETCH;
      pc_q        <= core_pkg::PC_START;
      trap_code_q <= '0;
    end else begin
      state_q <= state_d;
      if (in_wb && !is_trap) begin
        pc_q <= taken_q ? result_q : pc_q + 64'd4;
      end
      if (in_wb && is_trap) begin
        trap_code_q <= a0_lo_q;
      end
      // illegal word halts without a commit
      if (state_q == core_pkg::ST_EXECUTE && dec_i.op_class == core_pkg::CLS_ILLEGAL) begin
        trap_code_q <= 8'hff;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (state_q == core_pkg::ST_DECODE) begin
      inst_q <= imem_data_i;
    end
    if (state_q == core_pkg::ST_EXECUTE) begin
      result_q <= alu_result_i;
      taken_q  <= branch_taken_i;
      a0_lo_q  <= rs1_data_i[7:0];
    end
    if (state_q == core_pkg::ST_MEMORY) begin
      load_q <= mem_rdata_i;
    end
  end

  assign imem_addr_o = pc_q;
  assign inst_o      = inst_q;
  assign reg_we_o    = in_wb && (dec_i.op_class == core_pkg::CLS_ALU || is_load)
                       && (dec_i.rd != '0);
  assign reg_wdata_o = is_load ? load_q : result_q;
  assign mem_we_o    = (state_q == core_pkg::ST_MEMORY)
                       && (dec_i.op_class == core_pkg::CLS_STORE);

  assign commit_o = '{
    valid: in_wb,
    pc:    pc_q,
    inst:  inst_q,
    wen:   reg_we_o,
    rd:    dec_i.rd,
    wdata: reg_wdata_o
  };

  assign putch_valid_o = in_wb && (dec_i.op_class == core_pkg::CLS_PUTCH);
  assign putch_ch_o    = a0_lo_q;
  assign halt_o        = (state_q == core_pkg::ST_HALT);
  assign trap_code_o   = trap_code_q;

endmodule

/* design/core_pkg.sv */
// core package with shared widths, opcodes, FSM states and commit record
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported subset
  localparam logic [6:0] OP_OP     = 7'h33;
  localparam logic [6:0] OP_IMM    = 7'h13;
  localparam logic [6:0] OP_LUI    = 7'h37;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_LOAD   = 7'h03;
  localparam logic [6:0] OP_STORE  = 7'h23;
  localparam logic [6:0] OP_TRAP   = 7'h6b;

  localparam inst_t PUTCH_WORD = 32'h0000_0007;
  localparam addr_t PC_START   = 64'h8000_0000;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_PUTCH,
    CLS_TRAP,
    CLS_ILLEGAL
  } op_class_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK,
    ST_HALT
  } ctrl_state_e;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    inst_t    inst;
    logic     wen;
    reg_idx_t rd;
    xlen_t    wdata;
  } commit_t;

  typedef struct packed {
    op_class_e  op_class;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    xlen_t      imm;
    logic [2:0] funct3;
    logic       sub;
  } decode_t;

endpackage

/* design/cycle_counter.sv */
// cycle and retired instruction counters, frozen once the core halts
`timescale 1ns/1ns

module cycle_counter (
  input  logic        clock_i,
  input  logic        reset_i,
  input  logic        halt_i,
  input  logic        retire_i,
  output logic [63:0] cycle_cnt_o,
  output logic [63:0] instr_cnt_o
);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      cycle_cnt_o <= '0;
      instr_cnt_o <= '0;
    end else begin
      if (!halt_i) begin
        cycle_cnt_o <= cycle_cnt_o + 64'd1;
      end
      // one count per commit pulse
      if (retire_i && !halt_i) begin
        instr_cnt_o <= instr_cnt_o + 64'd1;
      end
    end
  end

endmodule

/* design/data_ram.sv */
// doubleword data RAM, synchronous write and asynchronous read
`timescale 1ns/1ns

module data_ram #(
  parameter int DEPTH = 256
) (
  input  logic            clock_i,
  input  logic            we_i,
  input  core_pkg::addr_t addr_i,
  input  core_pkg::xlen_t wdata_i,
  output core_pkg::xlen_t rdata_o
);

  localparam int AW = $clog2(DEPTH);

  core_pkg::xlen_t mem [DEPTH];
  logic [AW-1:0]   index;

  // byte offset dropped, upper bits wrap
  assign index = addr_i[3 +: AW];

  always_ff @(posedge clock_i) begin
    if (we_i) begin
      mem[index] <= wdata_i;
    end
  end

  assign rdata_o = mem[index];

endmodule

/* design/inst_decode.sv */
// instruction decoder producing register numbers, immediate and class
`timescale 1ns/1ns

module inst_decode (
  input  core_pkg::inst_t   inst_i,
  output core_pkg::decode_t dec_o
);

  logic [6:0]      opcode;
  logic [6:0]      funct7;
  logic            alu_f3_ok;
  core_pkg::xlen_t imm_i;
  core_pkg::xlen_t imm_s;
  core_pkg::xlen_t imm_b;
  core_pkg::xlen_t imm_u;

  assign opcode = inst_i[6:0];
  assign funct7 = inst_i[31:25];

  // add/sub, xor, or, and
  assign alu_f3_ok = (inst_i[14:12] == 3'b000) || (inst_i[14:12] == 3'b100)
                     || (inst_i[14:12] == 3'b110) || (inst_i[14:12] == 3'b111);

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

  always_comb begin
    dec_o.op_class = core_pkg::CLS_ILLEGAL;
    dec_o.rs1      = inst_i[19:15];
    dec_o.rs2      = inst_i[24:20];
    dec_o.rd       = inst_i[11:7];
    dec_o.imm      = '0;
    dec_o.funct3   = inst_i[14:12];
    dec_o.sub      = 1'b0;

    if (inst_i == core_pkg::PUTCH_WORD) begin
      dec_o.op_class = core_pkg::CLS_PUTCH;
      dec_o.rs1      = 5'd10;
    end else begin
      case (opcode)
        core_pkg::OP_OP: begin
          if (alu_f3_ok && (funct7 == 7'h00 || (funct7 == 7'h20 && inst_i[14:12] == 3'b000)))
          begin
            dec_o.op_class = core_pkg::CLS_ALU;
            dec_o.sub      = inst_i[30];
          end
        end
        // x0 as rs2 so the alu can merge rs2 and imm
        core_pkg::OP_IMM: begin
          if (alu_f3_ok) begin
            dec_o.op_class = core_pkg::CLS_ALU;
          end
          dec_o.rs2 = '0;
          dec_o.imm = imm_i;
        end
        core_pkg::OP_LUI: begin
          dec_o.op_class = core_pkg::CLS_ALU;
          dec_o.rs1      = '0;
          dec_o.rs2      = '0;
          dec_o.funct3   = 3'b000;
          dec_o.imm      = imm_u;
        end
        core_pkg::OP_BRANCH: begin
          if (inst_i[14:13] == 2'b00) begin
            dec_o.op_class = core_pkg::CLS_BRANCH;
          end
          dec_o.imm = imm_b;
        end
        core_pkg::OP_LOAD: begin
          if (inst_i[14:12] == 3'b011) begin
            dec_o.op_class = core_pkg::CLS_LOAD;
          end
          dec_o.imm = imm_i;
        end
        core_pkg::OP_STORE: begin
          if (inst_i[14:12] == 3'b011) begin
            dec_o.op_class = core_pkg::CLS_STORE;
          end
          dec_o.imm = imm_s;
        end
        core_pkg::OP_TRAP: begin
          dec_o.op_class = core_pkg::CLS_TRAP;
          dec_o.rs1      = 5'd10;
        end
        default: ;
      endcase
    end

    // only alu and load results write a register
    if (dec_o.op_class != core_pkg::CLS_ALU && dec_o.op_class != core_pkg::CLS_LOAD) begin
      dec_o.rd = '0;
    end
  end

endmodule

/* design/reg_file.sv */
// integer register file, 32 x 64 bits with x0 hardwired to zero
`timescale 1ns/1ns

module reg_file (
  input  logic               clock_i,
  input  logic               reset_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  logic               we_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::xlen_t    wdata_i,
  output core_pkg::xlen_t    rs1_data_o,
  output core_pkg::xlen_t    rs2_data_o
);

  core_pkg::xlen_t regs [32];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // asynchronous read ports
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* design/sim_top.sv */
// core top level wiring sequencer, datapath, memory and counters
`timescale 1ns/1ns

module sim_top #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic              clock,
  input  logic              reset,
  input  core_pkg::inst_t   imem_data_i,
  output core_pkg::addr_t   imem_addr_o,
  output logic              putch_valid_o,
  output logic [7:0]        putch_ch_o,
  output core_pkg::commit_t commit_o,
  output logic              trap_o,
  output logic [7:0]        trap_code_o,
  output logic [63:0]       cycle_cnt_o,
  output logic [63:0]       instr_cnt_o
);

  core_pkg::inst_t   inst;
  core_pkg::decode_t dec;
  core_pkg::xlen_t   rs1_data;
  core_pkg::xlen_t   rs2_data;
  core_pkg::xlen_t   alu_result;
  logic              branch_taken;
  core_pkg::xlen_t   mem_rdata;
  logic              mem_we;
  logic              reg_we;
  core_pkg::xlen_t   reg_wdata;

  core_control u_control (
    .clock_i        (clock),
    .reset_i        (reset),
    .imem_data_i    (imem_data_i),
    .dec_i          (dec),
    .alu_result_i   (alu_result),
    .branch_taken_i (branch_taken),
    .rs1_data_i     (rs1_data),
    .mem_rdata_i    (mem_rdata),
    .imem_addr_o    (imem_addr_o),
    .reg_we_o       (reg_we),
    .reg_wdata_o    (reg_wdata),
    .mem_we_o       (mem_we),
    .inst_o         (inst),
    .commit_o       (commit_o),
    .putch_valid_o  (putch_valid_o),
    .putch_ch_o     (putch_ch_o),
    .halt_o         (trap_o),
    .trap_code_o    (trap_code_o)
  );

  inst_decode u_decode (
    .inst_i (inst),
    .dec_o  (dec)
  );

  reg_file u_regs (
    .clock_i    (clock),
    .reset_i    (reset),
    .rs1_i      (dec.rs1),
    .rs2_i      (dec.rs2),
    .we_i       (reg_we),
    .rd_i       (dec.rd),
    .wdata_i    (reg_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // the pc doubles as the fetch address
  alu_unit u_alu (
    .dec_i          (dec),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .pc_i           (imem_addr_o),
    .result_o       (alu_result),
    .branch_taken_o (branch_taken)
  );

  data_ram #(
    .DEPTH (DMEM_DEPTH)
  ) u_dmem (
    .clock_i (clock),
    .we_i    (mem_we),
    .addr_i  (alu_result),
    .wdata_i (rs2_data),
    .rdata_o (mem_rdata)
  );

  cycle_counter u_counters (
    .clock_i     (clock),
    .reset_i     (reset),
    .halt_i      (trap_o),
    .retire_i    (commit_o.valid),
    .cycle_cnt_o (cycle_cnt_o),
    .instr_cnt_o (instr_cnt_o)
  );

endmodule

/* sim/sim_top_properties.sv */
// protocol properties of the core top level, bound into sim_top
`timescale 1ns/1ns

module sim_top_properties (
  input logic        clock,
  input logic        reset,
  input logic        commit_valid,
  input logic        trap,
  input logic        putch_valid,
  input logic [63:0] instr_cnt
);

  int unsigned assert_fails = 0;

  // one instruction in flight, so commits are never back to back
  commit_single: assert property (@(posedge clock) disable iff (reset)
    commit_valid |=> !commit_valid)
    else begin
      assert_fails++;
      $error("commit valid high in two consecutive cycles");
    end

  trap_sticky: assert property (@(posedge clock) disable iff (reset)
    trap |=> trap)
    else begin
      assert_fails++;
      $error("trap fell without a reset");
    end

  putch_commits: assert property (@(posedge clock) disable iff (reset)
    putch_valid |-> commit_valid)
    else begin
      assert_fails++;
      $error("putch pulse outside a commit");
    end

  halt_freezes_count: assert property (@(posedge clock) disable iff (reset)
    trap |=> $stable(instr_cnt))
    else begin
      assert_fails++;
      $error("retired count moved while halted");
    end

endmodule

bind sim_top sim_top_properties u_props (
  .clock        (clock),
  .reset        (reset),
  .commit_valid (commit_o.valid),
  .trap         (trap_o),
  .putch_valid  (putch_valid_o),
  .instr_cnt    (instr_cnt_o)
);

/* sim/tb_sim_top.sv */
// testbench for the multi-cycle core with an instruction-level reference model
`timescale 1ns/1ns

module tb_sim_top;

  localparam int DMEM_DEPTH   = 256;
  localparam int PROG_WORDS   = 64;
  localparam int RESET_CYCLES = 5;
  localparam int TEST_LIMIT   = 300;
  localparam int NUM_TESTS    = 6;
  localparam int GLOBAL_LIMIT = NUM_TESTS * (TEST_LIMIT + RESET_CYCLES + 2) + 20;

  logic              clock;
  logic              reset;
  core_pkg::inst_t   imem_data_i;
  core_pkg::addr_t   imem_addr_o;
  logic              putch_valid_o;
  logic [7:0]        putch_ch_o;
  core_pkg::commit_t commit_o;
  logic              trap_o;
  logic [7:0]        trap_code_o;
  logic [63:0]       cycle_cnt_o;
  logic [63:0]       instr_cnt_o;

  core_pkg::inst_t   prog [PROG_WORDS];
  int                prog_len = 0;
  logic [31:0]       lfsr = 32'h942e_040a;
  int                mismatches = 0;
  int                other_errs = 0;
  int unsigned       run_cycles = 0;
  string             test_name = "";

  // reference model state and expectations
  core_pkg::xlen_t   mregs [32];
  core_pkg::xlen_t   mmem [int];
  core_pkg::commit_t exp_commits [$];
  logic [7:0]        exp_chars [$];
  logic [7:0]        exp_trap;
  int                exp_instr;
  int                exp_cycles;

  sim_top #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_dut (
    .clock         (clock),
    .reset         (reset),
    .imem_data_i   (imem_data_i),
    .imem_addr_o   (imem_addr_o),
    .putch_valid_o (putch_valid_o),
    .putch_ch_o    (putch_ch_o),
    .commit_o      (commit_o),
    .trap_o        (trap_o),
    .trap_code_o   (trap_code_o),
    .cycle_cnt_o   (cycle_cnt_o),
    .instr_cnt_o   (instr_cnt_o)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  // unused words are traps that carry their index
  function automatic core_pkg::inst_t fill_word(input core_pkg::addr_t idx);
    return {idx[24:0] ^ idx[49:25] ^ {11'h0, idx[63:50]}, core_pkg::OP_TRAP};
  endfunction

  function automatic core_pkg::inst_t fetch_word(input core_pkg::addr_t addr);
    core_pkg::addr_t idx;
    idx = (addr - core_pkg::PC_START) >> 2;
    if (idx < PROG_WORDS) begin
      return prog[idx];
    end
    return fill_word(idx);
  endfunction

  // one-cycle fetch latency, word valid in DECODE
  always @(posedge clock) begin
    imem_data_i <= fetch_word(imem_addr_o);
  end

  always @(posedge clock) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= GLOBAL_LIMIT) begin
      $display("timeout: run exceeded %0d cycles during %s", GLOBAL_LIMIT, test_name);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic core_pkg::inst_t i_format(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic core_pkg::inst_t r_format(input logic [4:0] rd, input logic [2:0] f3,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [6:0] f7);
    return {f7, rs2, rs1, f3, rd, core_pkg::OP_OP};
  endfunction

  function automatic core_pkg::inst_t s_format(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], core_pkg::OP_STORE};
  endfunction

  function automatic core_pkg::inst_t b_format(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OP_BRANCH};
  endfunction

  function automatic core_pkg::inst_t u_format(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, core_pkg::OP_LUI};
  endfunction

  function automatic core_pkg::xlen_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic int dword_index(input core_pkg::addr_t ea);
    return int'((ea >> 3) % DMEM_DEPTH);
  endfunction

  // funct3 000 add or sub, 100 xor, 110 or, 111 and
  function automatic core_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic sub,
                                              input core_pkg::xlen_t a, input core_pkg::xlen_t b);
    case (f3)
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  task automatic clear_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = fill_word(core_pkg::addr_t'(i));
    end
    prog_len = 0;
  endtask

  task automatic emit(input core_pkg::inst_t w);
    if (prog_len >= PROG_WORDS) begin
      $display("%s: program longer than %0d words", test_name, PROG_WORDS);
      other_errs++;
    end else begin
      prog[prog_len] = w;
      prog_len++;
    end
  endtask

  task automatic run_model();
    core_pkg::addr_t   pc;
    core_pkg::addr_t   next_pc;
    core_pkg::addr_t   ea;
    core_pkg::inst_t   w;
    core_pkg::xlen_t   v1;
    core_pkg::xlen_t   v2;
    core_pkg::xlen_t   res;
    core_pkg::commit_t c;
    logic              writes;
    logic              done;
    int                steps;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mmem.delete();
    exp_commits.delete();
    exp_chars.delete();
    exp_instr  = 0;
    exp_cycles = 0;
    exp_trap   = 8'h00;
    pc    = core_pkg::PC_START;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < TEST_LIMIT / 4) begin
      w       = fetch_word(pc);
      v1      = mregs[w[19:15]];
      v2      = mregs[w[24:20]];
      res     = '0;
      writes  = 1'b0;
      next_pc = pc + 64'd4;
      exp_cycles += 4;
      if (w == core_pkg::PUTCH_WORD) begin
        exp_chars.push_back(mregs[10][7:0]);
      end else begin
        case (w[6:0])
          core_pkg::OP_IMM: begin
            res    = alu_ref(w[14:12], 1'b0, v1, sext12(w[31:20]));
            writes = 1'b1;
          end
          core_pkg::OP_OP: begin
            res    = alu_ref(w[14:12], w[30], v1, v2);
            writes = 1'b1;
          end
          core_pkg::OP_LUI: begin
            res    = {{32{w[31]}}, w[31:12], 12'h000};
            writes = 1'b1;
          end
          core_pkg::OP_BRANCH: begin
            // funct3 bit 0 turns beq into bne
            if ((v1 == v2) != w[12]) begin
              next_pc = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
          end
          core_pkg::OP_LOAD: begin
            ea     = v1 + sext12(w[31:20]);
            res    = mmem.exists(dword_index(ea)) ? mmem[dword_index(ea)] : '0;
            writes = 1'b1;
            exp_cycles += 1;
          end
          core_pkg::OP_STORE: begin
            ea = v1 + sext12({w[31:25], w[11:7]});
            mmem[dword_index(ea)] = v2;
            exp_cycles += 1;
          end
          core_pkg::OP_TRAP: begin
            exp_trap = mregs[10][7:0];
            done     = 1'b1;
          end
          default: begin
            // illegal word halts after EXECUTE without a commit
            exp_trap = 8'hff;
            exp_cycles -= 1;
            done = 1'b1;
          end
        endcase
      end
      if (w[6:0] != core_pkg::OP_TRAP && done) begin
        break;
      end
      c       = '0;
      c.valid = 1'b1;
      c.pc    = pc;
      c.inst  = w;
      c.wen   = writes && (w[11:7] != 5'd0);
      c.rd    = c.wen ? w[11:7] : 5'd0;
      c.wdata = res;
      if (c.wen) begin
        mregs[w[11:7]] = res;
      end
      exp_commits.push_back(c);
      exp_instr++;
      pc = next_pc;
      steps++;
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("MISMATCH %s in %s: got %h, expected %h", sig, test_name, got, exp);
    mismatches++;
  endtask

  task automatic check_commit();
    core_pkg::commit_t exp;
    if (exp_commits.size() == 0) begin
      $display("%s: commit at pc %h beyond the expected program", test_name, commit_o.pc);
      other_errs++;
    end else begin
      exp = exp_commits.pop_front();
      if (commit_o.pc !== exp.pc) begin
        report_mismatch("commit_o.pc", commit_o.pc, exp.pc);
      end
      if (commit_o.inst !== exp.inst) begin
        report_mismatch("commit_o.inst", 64'(commit_o.inst), 64'(exp.inst));
      end
      if (commit_o.wen !== exp.wen) begin
        report_mismatch("commit_o.wen", 64'(commit_o.wen), 64'(exp.wen));
      end
      if (exp.wen && commit_o.rd !== exp.rd) begin
        report_mismatch("commit_o.rd", 64'(commit_o.rd), 64'(exp.rd));
      end
      if (exp.wen && commit_o.wdata !== exp.wdata) begin
        report_mismatch("commit_o.wdata", commit_o.wdata, exp.wdata);
      end
    end
  endtask

  task automatic check_putch();
    logic [7:0] exp;
    if (exp_chars.size() == 0) begin
      $display("%s: unexpected putch pulse with %h", test_name, putch_ch_o);
      other_errs++;
    end else begin
      exp = exp_chars.pop_front();
      if (putch_ch_o !== exp) begin
        report_mismatch("putch_ch_o", 64'(putch_ch_o), 64'(exp));
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  endtask

  // outputs are sampled at the falling edge, away from the driving edge
  task automatic run_and_check(input string name);
    int   cycles;
    logic fetch_due;
    test_name = name;
    run_model();
    apply_reset();
    cycles    = 0;
    fetch_due = 1'b1;
    while (!trap_o && cycles < TEST_LIMIT) begin
      @(negedge clock);
      // the cycle after reset or a commit is a FETCH of the next expected pc
      if (fetch_due && exp_commits.size() != 0 && imem_addr_o !== exp_commits[0].pc) begin
        report_mismatch("imem_addr_o", imem_addr_o, exp_commits[0].pc);
      end
      fetch_due = commit_o.valid;
      if (commit_o.valid) begin
        check_commit();
      end
      if (putch_valid_o) begin
        check_putch();
      end
      cycles++;
    end
    if (!trap_o) begin
      $display("%s: core did not halt within %0d cycles", name, TEST_LIMIT);
      other_errs++;
    end else begin
      if (trap_code_o !== exp_trap) begin
        report_mismatch("trap_code_o", 64'(trap_code_o), 64'(exp_trap));
      end
      if (instr_cnt_o !== 64'(exp_instr)) begin
        report_mismatch("instr_cnt_o", instr_cnt_o, 64'(exp_instr));
      end
      if (cycle_cnt_o !== 64'(exp_cycles)) begin
        report_mismatch("cycle_cnt_o", cycle_cnt_o, 64'(exp_cycles));
      end
    end
    if (exp_commits.size() != 0) begin
      $display("%s: %0d expected commits never appeared", name, exp_commits.size());
      other_errs++;
    end
    if (exp_chars.size() != 0) begin
      $display("%s: %0d expected characters never appeared", name, exp_chars.size());
      other_errs++;
    end
  endtask

  task automatic alu_sequence();
    logic [2:0] imm_f3 [4] = '{3'b000, 3'b100, 3'b110, 3'b111};
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    clear_program();
    for (int i = 1; i < 8; i++) begin
      emit(i_format(core_pkg::OP_IMM, 5'(i), 3'b000, 5'(i - 1), 12'(rand_bits(12))));
    end
    for (int k = 0; k < 12; k++) begin
      rd  = 5'(rand_bits(4));
      rs1 = 5'(rand_bits(4));
      rs2 = 5'(rand_bits(4));
      case (k % 6)
        0:       emit(r_format(rd, 3'b000, rs1, rs2, 7'h00));
        1:       emit(r_format(rd, 3'b000, rs1, rs2, 7'h20));
        2:       emit(r_format(rd, 3'b100, rs1, rs2, 7'h00));
        3:       emit(r_format(rd, 3'b110, rs1, rs2, 7'h00));
        4:       emit(r_format(rd, 3'b111, rs1, rs2, 7'h00));
        default: emit(u_format(rd, 20'(rand_bits(20))));
      endcase
      emit(i_format(core_pkg::OP_IMM, rd, imm_f3[k % 4], rs1, 12'(rand_bits(12))));
    end
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("alu sequence");
  endtask

  task automatic memory_round_trip();
    clear_program();
    emit(u_format(5'd6, 20'(rand_bits(20))));
    emit(i_format(core_pkg::OP_IMM, 5'd6, 3'b000, 5'd6, 12'(rand_bits(12))));
    emit(u_format(5'd7, 20'(rand_bits(20))));
    emit(r_format(5'd7, 3'b100, 5'd7, 5'd6, 7'h00));
    // base register 256
    emit(i_format(core_pkg::OP_IMM, 5'd2, 3'b000, 5'd0, 12'h100));
    emit(s_format(5'd0, 5'd6, 12'h008));
    emit(s_format(5'd2, 5'd7, 12'h018));
    emit(i_format(core_pkg::OP_LOAD, 5'd8, 3'b011, 5'd0, 12'h008));
    emit(i_format(core_pkg::OP_LOAD, 5'd9, 3'b011, 5'd2, 12'h018));
    emit(s_format(5'd0, 5'd9, 12'h008));
    emit(i_format(core_pkg::OP_LOAD, 5'd10, 3'b011, 5'd0, 12'h008));
    emit(i_format(core_pkg::OP_LOAD, 5'd11, 3'b011, 5'd0, 12'h118));
    // negative offset back to address 8
    emit(i_format(core_pkg::OP_LOAD, 5'd12, 3'b011, 5'd2, 12'hf08));
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("memory round trip");
  endtask

  task automatic branch_paths();
    clear_program();
    emit(i_format(core_pkg::OP_IMM, 5'd1, 3'b000, 5'd0, 12'd5));
    emit(i_format(core_pkg::OP_IMM, 5'd2, 3'b000, 5'd0, 12'd5));
    emit(i_format(core_pkg::OP_IMM, 5'd3, 3'b000, 5'd0, 12'd7));
    emit(b_format(3'b000, 5'd1, 5'd2, 13'd8));
    emit(i_format(core_pkg::OP_IMM, 5'd4, 3'b000, 5'd4, 12'd1));
    emit(b_format(3'b001, 5'd1, 5'd3, 13'd8));
    emit(i_format(core_pkg::OP_IMM, 5'd4, 3'b000, 5'd4, 12'd2));
    emit(b_format(3'b000, 5'd1, 5'd3, 13'd8));
    emit(i_format(core_pkg::OP_IMM, 5'd4, 3'b000, 5'd4, 12'd4));
    emit(b_format(3'b001, 5'd1, 5'd2, 13'd8));
    emit(i_format(core_pkg::OP_IMM, 5'd4, 3'b000, 5'd4, 12'd8));
    // countdown loop with a backward bne
    emit(i_format(core_pkg::OP_IMM, 5'd5, 3'b000, 5'd0, 12'd3));
    emit(i_format(core_pkg::OP_IMM, 5'd5, 3'b000, 5'd5, 12'hfff));
    emit(b_format(3'b001, 5'd5, 5'd0, 13'h1ffc));
    emit(i_format(core_pkg::OP_IMM, 5'd10, 3'b000, 5'd4, 12'd0));
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("branch paths");
  endtask

  task automatic putch_output();
    clear_program();
    for (int i = 0; i < 4; i++) begin
      emit(i_format(core_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, {4'h0, 8'(rand_bits(8))}));
      emit(core_pkg::PUTCH_WORD);
    end
    // back to back putch words
    emit(i_format(core_pkg::OP_IMM, 5'd10, 3'b000, 5'd10, 12'd1));
    emit(core_pkg::PUTCH_WORD);
    emit(core_pkg::PUTCH_WORD);
    emit(i_format(core_pkg::OP_IMM, 5'd10, 3'b000, 5'd0, 12'h2a));
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("putch output");
  endtask

  task automatic trap_and_counters();
    clear_program();
    emit(i_format(core_pkg::OP_IMM, 5'd1, 3'b000, 5'd0, 12'(rand_bits(12))));
    emit(s_format(5'd0, 5'd1, 12'h040));
    emit(i_format(core_pkg::OP_LOAD, 5'd2, 3'b011, 5'd0, 12'h040));
    emit(r_format(5'd3, 3'b000, 5'd1, 5'd2, 7'h00));
    emit(b_format(3'b000, 5'd0, 5'd0, 13'd8));
    emit(i_format(core_pkg::OP_IMM, 5'd3, 3'b000, 5'd0, 12'd0));
    emit(i_format(core_pkg::OP_IMM, 5'd10, 3'b000, 5'd3, {4'h0, 8'(rand_bits(8))}));
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("trap and counters");
  endtask

  task automatic x0_writes();
    clear_program();
    emit(i_format(core_pkg::OP_IMM, 5'd1, 3'b000, 5'd0, 12'(rand_bits(12))));
    emit(i_format(core_pkg::OP_IMM, 5'd0, 3'b000, 5'd1, 12'(rand_bits(12))));
    emit(r_format(5'd0, 3'b000, 5'd1, 5'd1, 7'h00));
    emit(u_format(5'd0, 20'(rand_bits(20))));
    emit(s_format(5'd0, 5'd1, 12'h020));
    emit(i_format(core_pkg::OP_LOAD, 5'd0, 3'b011, 5'd0, 12'h020));
    emit(r_format(5'd5, 3'b000, 5'd0, 5'd0, 7'h00));
    emit(r_format(5'd6, 3'b100, 5'd0, 5'd1, 7'h00));
    emit(r_format(5'd10, 3'b110, 5'd0, 5'd0, 7'h00));
    emit({25'd0, core_pkg::OP_TRAP});
    run_and_check("x0 writes");
  endtask

  initial begin
    int total;
    reset       = 1'b1;
    imem_data_i = '0;
    clear_program();
    alu_sequence();
    memory_round_trip();
    branch_paths();
    putch_output();
    trap_and_counters();
    x0_writes();
    total = mismatches + other_errs + int'(u_dut.u_props.assert_fails);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, other_errs, u_dut.u_props.assert_fails);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
